// File: hdl/hud_pkg.sv
package hud_pkg;

  typedef logic [9:0] coord_t;   // Screen or sprite-relative pixel position
  typedef logic [6:0] seconds_t; // 0 to 99
  typedef logic [3:0] digit_t;
  typedef logic [7:0] color_t;   // RGB332

  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    EXPIRED
  } timer_state_t;

  // Reduced frame totals
  localparam coord_t H_ACTIVE = 10'd32;
  localparam coord_t H_TOTAL  = 10'd40;
  localparam coord_t V_ACTIVE = 10'd20;
  localparam coord_t V_TOTAL  = 10'd24;

  localparam coord_t SPRITE_WIDTH  = 10'd10; // One digit
  localparam coord_t SPRITE_HEIGHT = 10'd13;
  localparam coord_t SPRITE_X      = 10'd6;  // Top-left corner of both digits
  localparam coord_t SPRITE_Y      = 10'd4;

  localparam int       FRAMES_PER_SECOND = 3;
  localparam seconds_t MAX_SECONDS       = 7'd99;

  localparam color_t COUNTER_COLOR     = 8'b00000000;
  localparam color_t TRANSPARENT_COLOR = 8'b11100011;
  localparam color_t BACKGROUND_COLOR  = 8'h49;

  // Bit 9 is the leftmost column
  localparam logic [SPRITE_WIDTH-1:0] GLYPH [10][SPRITE_HEIGHT] = '{
    '{'h000, 'h1FE, 'h186, 'h186, 'h186, 'h186, 'h186,
      'h186, 'h186, 'h186, 'h186, 'h1FE, 'h000},
    '{'h000, 'h070, 'h0F0, 'h030, 'h030, 'h030, 'h030,
      'h030, 'h030, 'h030, 'h030, 'h0FC, 'h000},
    '{'h000, 'h1FE, 'h006, 'h006, 'h006, 'h006, 'h1FE,
      'h180, 'h180, 'h180, 'h180, 'h1FE, 'h000},
    '{'h000, 'h1FE, 'h006, 'h006, 'h006, 'h006, 'h1FE,
      'h006, 'h006, 'h006, 'h006, 'h1FE, 'h000},
    '{'h000, 'h186, 'h186, 'h186, 'h186, 'h186, 'h1FE,
      'h006, 'h006, 'h006, 'h006, 'h006, 'h000},
    '{'h000, 'h1FE, 'h180, 'h180, 'h180, 'h180, 'h1FE,
      'h006, 'h006, 'h006, 'h006, 'h1FE, 'h000},
    '{'h000, 'h1FE, 'h180, 'h180, 'h180, 'h180, 'h1FE,
      'h186, 'h186, 'h186, 'h186, 'h1FE, 'h000},
    '{'h000, 'h1FE, 'h006, 'h006, 'h00C, 'h00C, 'h018,
      'h018, 'h030, 'h030, 'h030, 'h030, 'h000},
    '{'h000, 'h1FE, 'h186, 'h186, 'h186, 'h186, 'h1FE,
      'h186, 'h186, 'h186, 'h186, 'h1FE, 'h000},
    '{'h000, 'h1FE, 'h186, 'h186, 'h186, 'h186, 'h1FE,
      'h006, 'h006, 'h006, 'h006, 'h1FE, 'h000}
  };

endpackage

// File: hdl/scan_if.sv
`timescale 1ns/1ps

interface scan_if;

  hud_pkg::coord_t x;
  hud_pkg::coord_t y;
  logic            active;      // Inside the visible area
  logic            frame_start; // One cycle at (0,0)

  modport src (
    output x,
    output y,
    output active,
    output frame_start
  );

  modport dst (
    input x,
    input y,
    input active,
    input frame_start
  );

endinterface

// File: hdl/scan_timing.sv
`timescale 1ns/1ps

module scan_timing (
  input  logic clk,
  input  logic reset,
  scan_if.src  scan
);

  hud_pkg::coord_t next_x;
  hud_pkg::coord_t next_y;
  logic            last_col;
  logic            last_row;

  assign last_col = (scan.x == hud_pkg::H_TOTAL - 1);
  assign last_row = (scan.y == hud_pkg::V_TOTAL - 1);

  always_comb begin
    next_x = last_col ? '0 : scan.x + 1'b1;
    next_y = scan.y;
    if (last_col) begin
      next_y = last_row ? '0 : scan.y + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      scan.x           <= '0;
      scan.y           <= '0;
      scan.active      <= 1'b1; // Pixel (0,0) is visible
      scan.frame_start <= 1'b0; // No strobe on the first cycle
    end else begin
      scan.x           <= next_x;
      scan.y           <= next_y;
      scan.active      <= (next_x < hud_pkg::H_ACTIVE) && (next_y < hud_pkg::V_ACTIVE);
      // Wrap from the last pixel back to the origin
      scan.frame_start <= last_col && last_row;
    end
  end

endmodule

// File: hdl/game_timer.sv
`timescale 1ns/1ps

module game_timer (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  hud_pkg::seconds_t   load_seconds,
  input  logic                pause,
  scan_if.dst                 scan,
  output hud_pkg::seconds_t   seconds_left,
  output logic                expired
);

  localparam int CNT_W = $clog2(hud_pkg::FRAMES_PER_SECOND);

  hud_pkg::timer_state_t state;
  hud_pkg::seconds_t     load_value;
  logic [CNT_W-1:0]      frame_cnt;
  logic                  step;

  assign load_value = (load_seconds > hud_pkg::MAX_SECONDS) ? hud_pkg::MAX_SECONDS
                                                            : load_seconds;
  assign step       = scan.frame_start && !pause; // Frames while paused are not counted
  assign expired    = (state == hud_pkg::EXPIRED);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= hud_pkg::IDLE;
      seconds_left <= '0;
      frame_cnt    <= '0;
    end else if (start) begin
      // Restart from any state
      frame_cnt    <= '0;
      seconds_left <= load_value;
      state        <= (load_value == '0) ? hud_pkg::EXPIRED : hud_pkg::RUNNING;
    end else begin
      case (state)
        hud_pkg::RUNNING: begin
          if (step) begin
            if (frame_cnt == hud_pkg::FRAMES_PER_SECOND - 1) begin
              frame_cnt    <= '0;
              seconds_left <= seconds_left - 1'b1;
              if (seconds_left == 7'd1) begin
                state <= hud_pkg::EXPIRED; // Last second just ran out
              end
            end else begin
              frame_cnt <= frame_cnt + 1'b1;
            end
          end
        end
        hud_pkg::EXPIRED: state <= hud_pkg::EXPIRED; // Held until the next start
        default:          state <= hud_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: hdl/timer_sprite.sv
`timescale 1ns/1ps

module timer_sprite (
  input  logic              clk,
  input  hud_pkg::coord_t   rel_x,
  input  hud_pkg::coord_t   rel_y,
  input  hud_pkg::seconds_t seconds,
  output hud_pkg::color_t   pixel_data
);

  hud_pkg::digit_t tens;
  hud_pkg::digit_t ones;
  hud_pkg::digit_t digit;
  hud_pkg::coord_t col;
  logic            left_digit;
  logic            in_range;
  logic            blank;
  logic [3:0]      bit_idx;
  logic            glyph_bit;

  assign tens = hud_pkg::digit_t'(seconds / 7'd10);
  assign ones = hud_pkg::digit_t'(seconds % 7'd10);

  // Tens on the left half and ones on the right
  assign left_digit = (rel_x < hud_pkg::SPRITE_WIDTH);
  assign digit      = left_digit ? tens : ones;
  assign col        = left_digit ? rel_x : rel_x - hud_pkg::SPRITE_WIDTH;

  // Negative offsets wrap to large values and land here too
  assign in_range = (rel_x < 2 * hud_pkg::SPRITE_WIDTH) &&
                    (rel_y < hud_pkg::SPRITE_HEIGHT);
  assign blank    = left_digit && (tens == '0); // No leading zero

  assign bit_idx = 4'(hud_pkg::SPRITE_WIDTH - 1) - col[3:0];

  always_comb begin
    glyph_bit = 1'b0;
    if (in_range) begin
      glyph_bit = hud_pkg::GLYPH[digit][rel_y[3:0]][bit_idx];
    end
  end

  // One cycle of glyph lookup
  always_ff @(posedge clk) begin
    if (in_range && !blank && glyph_bit) begin
      pixel_data <= hud_pkg::COUNTER_COLOR;
    end else begin
      pixel_data <= hud_pkg::TRANSPARENT_COLOR;
    end
  end

endmodule

// File: hdl/hud_overlay.sv
`timescale 1ns/1ps

module hud_overlay (
  input  logic              clk,
  input  logic              reset,
  scan_if.dst               scan,
  input  hud_pkg::seconds_t seconds_left,
  output hud_pkg::coord_t   pixel_x,
  output hud_pkg::coord_t   pixel_y,
  output logic              pixel_active,
  output logic              frame_start,
  output hud_pkg::color_t   pixel_color
);

  hud_pkg::seconds_t shown_q;
  hud_pkg::seconds_t shown;
  hud_pkg::coord_t   rel_x;
  hud_pkg::coord_t   rel_y;
  hud_pkg::color_t   sprite_data;
  hud_pkg::coord_t   x_d1;
  hud_pkg::coord_t   y_d1;
  logic              active_d1;
  logic              frame_start_d1;

  // Value at frame_start holds for the whole frame
  assign shown = scan.frame_start ? seconds_left : shown_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      shown_q <= '0;
    end else begin
      shown_q <= shown;
    end
  end

  assign rel_x = scan.x - hud_pkg::SPRITE_X;
  assign rel_y = scan.y - hud_pkg::SPRITE_Y;

  timer_sprite sprite_i (
    .clk        (clk),
    .rel_x      (rel_x),
    .rel_y      (rel_y),
    .seconds    (shown),
    .pixel_data (sprite_data)
  );

  always_ff @(posedge clk) begin
    x_d1    <= scan.x; // Matches the sprite lookup
    y_d1    <= scan.y;
    pixel_x <= x_d1;
    pixel_y <= y_d1;
    if (!active_d1) begin
      pixel_color <= '0; // Blanking
    end else if (sprite_data == hud_pkg::TRANSPARENT_COLOR) begin
      pixel_color <= hud_pkg::BACKGROUND_COLOR;
    end else begin
      pixel_color <= sprite_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active_d1      <= 1'b0;
      frame_start_d1 <= 1'b0;
      pixel_active   <= 1'b0;
      frame_start    <= 1'b0;
    end else begin
      active_d1      <= scan.active;
      frame_start_d1 <= scan.frame_start;
      pixel_active   <= active_d1;
      frame_start    <= frame_start_d1;
    end
  end

endmodule

// File: hdl/hud_top.sv
`timescale 1ns/1ps

module hud_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  hud_pkg::seconds_t load_seconds,
  input  logic              pause,
  output hud_pkg::coord_t   pixel_x,
  output hud_pkg::coord_t   pixel_y,
  output logic              pixel_active,
  output logic              frame_start,
  output hud_pkg::color_t   pixel_color,
  output hud_pkg::seconds_t seconds_left,
  output logic              expired
);

  scan_if scan_bus ();

  scan_timing scan_i (
    .clk   (clk),
    .reset (reset),
    .scan  (scan_bus.src)
  );

  // Steps on the undelayed frame strobe
  game_timer timer_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .load_seconds (load_seconds),
    .pause        (pause),
    .scan         (scan_bus.dst),
    .seconds_left (seconds_left),
    .expired      (expired)
  );

  hud_overlay overlay_i (
    .clk          (clk),
    .reset        (reset),
    .scan         (scan_bus.dst),
    .seconds_left (seconds_left),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .pixel_active (pixel_active),
    .frame_start  (frame_start),
    .pixel_color  (pixel_color)
  );

endmodule

// File: bench/hud_props.sv
`timescale 1ns/1ps

module hud_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  start,
  input logic                  frame_start,
  input hud_pkg::seconds_t     seconds_left,
  input logic                  expired,
  input hud_pkg::timer_state_t state
);

  int failures = 0;

  frame_single: assert property (@(posedge clk) disable iff (reset)
    frame_start |=> !frame_start)
    else begin
      failures++;
      $error("frame_start held for more than one cycle");
    end

  seconds_limit: assert property (@(posedge clk) disable iff (reset)
    seconds_left <= hud_pkg::MAX_SECONDS)
    else begin
      failures++;
      $error("seconds_left above the maximum");
    end

  expired_zero: assert property (@(posedge clk) disable iff (reset)
    expired |-> (seconds_left == '0))
    else begin
      failures++;
      $error("expired with time remaining");
    end

  // An idle timer has never been loaded
  idle_zero: assert property (@(posedge clk) disable iff (reset)
    (state == hud_pkg::IDLE) |-> (seconds_left == '0))
    else begin
      failures++;
      $error("seconds_left nonzero while idle");
    end

  no_count_up: assert property (@(posedge clk) disable iff (reset)
    !start |=> seconds_left <= $past(seconds_left))
    else begin
      failures++;
      $error("seconds_left increased without start");
    end

endmodule

bind hud_top hud_props props_i (.*, .state(timer_i.state));

// File: bench/hud_checker.sv
`timescale 1ns/1ps

module hud_checker (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  hud_pkg::seconds_t load_seconds,
  input  logic              pause,
  input  hud_pkg::coord_t   pixel_x,
  input  hud_pkg::coord_t   pixel_y,
  input  logic              pixel_active,
  input  logic              frame_start,
  input  hud_pkg::color_t   pixel_color,
  input  hud_pkg::seconds_t seconds_left,
  input  logic              expired,
  output int                mismatch_count
);

  int                    errors = 0;
  logic [9:0]            in_d1 = '0; // {reset, start, pause, load}
  logic [9:0]            in_d2 = '0;
  logic [7:0]            obs_d1;     // {expired, seconds_left}
  logic [7:0]            obs_d2;
  logic                  model_valid = 1'b0;
  hud_pkg::timer_state_t m_state;
  int                    m_sec;
  int                    m_cnt;
  int                    settle = 0; // Negedges since reset went low
  int                    exp_x;
  int                    exp_y;
  int                    shown;
  logic                  first_frame;

  assign mismatch_count = errors;

  task automatic report(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  function automatic hud_pkg::color_t expected_color(input int x, input int y, input int sec);
    int rx;
    int ry;
    int w;
    w  = int'(hud_pkg::SPRITE_WIDTH);
    rx = x - int'(hud_pkg::SPRITE_X);
    ry = y - int'(hud_pkg::SPRITE_Y);
    if (x >= int'(hud_pkg::H_ACTIVE) || y >= int'(hud_pkg::V_ACTIVE)) begin
      return '0;
    end
    if (rx < 0 || ry < 0 || rx >= 2 * w || ry >= int'(hud_pkg::SPRITE_HEIGHT) ||
        (rx < w && sec < 10)) begin
      return hud_pkg::BACKGROUND_COLOR; // Off the sprite or blank tens
    end
    if (hud_pkg::GLYPH[(rx < w) ? sec / 10 : sec % 10][ry][w - 1 - rx % w]) begin
      return hud_pkg::COUNTER_COLOR;
    end
    return hud_pkg::BACKGROUND_COLOR;
  endfunction

  // Timer model runs two cycles behind, in step with the output frame_start
  task automatic step_model(input logic [9:0] in, input logic fs);
    int load;
    load = (in[6:0] > hud_pkg::MAX_SECONDS) ? int'(hud_pkg::MAX_SECONDS) : int'(in[6:0]);
    if (in[9]) begin
      m_state     = hud_pkg::IDLE;
      m_sec       = 0;
      m_cnt       = 0;
      model_valid = 1'b1;
    end else if (in[8]) begin
      m_sec   = load;
      m_cnt   = 0;
      m_state = (load == 0) ? hud_pkg::EXPIRED : hud_pkg::RUNNING;
    end else if (m_state == hud_pkg::RUNNING && fs && !in[7]) begin
      m_cnt++;
      if (m_cnt == hud_pkg::FRAMES_PER_SECOND) begin
        m_cnt = 0;
        m_sec--;
        if (m_sec == 0) begin
          m_state = hud_pkg::EXPIRED;
        end
      end
    end
  endtask

  task automatic check_pixel;
    logic exp_active;
    logic exp_frame;
    exp_active = (exp_x < int'(hud_pkg::H_ACTIVE)) && (exp_y < int'(hud_pkg::V_ACTIVE));
    exp_frame  = (exp_x == 0) && (exp_y == 0) && !first_frame;
    if (pixel_x !== 10'(exp_x) || pixel_y !== 10'(exp_y)) begin
      report($sformatf("pixel at (%0d,%0d), expected (%0d,%0d)", pixel_x, pixel_y, exp_x, exp_y));
    end
    if (pixel_active !== exp_active || frame_start !== exp_frame) begin
      report($sformatf("active %b frame_start %b at (%0d,%0d), expected %b %b",
                       pixel_active, frame_start, exp_x, exp_y, exp_active, exp_frame));
    end
    if (exp_frame) begin
      shown = m_sec; // Held for the whole frame
    end
    if (pixel_color !== expected_color(exp_x, exp_y, shown)) begin
      report($sformatf("colour %h at (%0d,%0d) showing %0d, expected %h", pixel_color,
                       exp_x, exp_y, shown, expected_color(exp_x, exp_y, shown)));
    end
    exp_x++;
    if (exp_x == int'(hud_pkg::H_TOTAL)) begin
      exp_x       = 0;
      exp_y       = (exp_y + 1) % int'(hud_pkg::V_TOTAL);
      first_frame = first_frame && (exp_y != 0);
    end
  endtask

  always @(negedge clk) begin
    if (model_valid && obs_d2 !== {m_state == hud_pkg::EXPIRED, 7'(m_sec)}) begin
      report($sformatf("seconds_left %0d expired %b, expected %0d %b", obs_d2[6:0],
                       obs_d2[7], m_sec, m_state == hud_pkg::EXPIRED));
    end
    if (reset) begin
      settle = 0;
      shown  = 0;
    end else begin
      if (settle == 2) begin
        exp_x       = 0; // Output pipeline full so the walk starts at the origin
        exp_y       = 0;
        first_frame = 1'b1;
      end
      if (settle < 3) begin
        settle++;
      end
      if (settle == 3) begin
        check_pixel();
      end
    end
    step_model(in_d2, frame_start === 1'b1);
    in_d2  = in_d1;
    in_d1  = {reset, start, pause, load_seconds};
    obs_d2 = obs_d1;
    obs_d1 = {expired, seconds_left};
  end

endmodule

// File: bench/hud_tb.sv
`timescale 1ns/1ps

module hud_tb;

  logic              clk;
  logic              reset;
  logic              start;
  logic              pause;
  hud_pkg::seconds_t load_seconds;
  hud_pkg::coord_t   pixel_x;
  hud_pkg::coord_t   pixel_y;
  logic              pixel_active;
  logic              frame_start;
  hud_pkg::color_t   pixel_color;
  hud_pkg::seconds_t seconds_left;
  logic              expired;
  logic [15:0]       lfsr = 16'd94;
  int                timeouts = 0;
  int                mismatches;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  hud_top dut_i (.*);

  hud_checker checker_i (.*, .mismatch_count(mismatches));

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int r);
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = (r << 1) | lfsr[0];
    end
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_frame_start;
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (frame_start !== 1'b1 && n < hud_pkg::H_TOTAL * hud_pkg::V_TOTAL + 4);
    if (frame_start !== 1'b1) begin
      timeouts++;
      $display("Timeout at %0t: no frame_start within a frame", $time);
    end
  endtask

  task automatic wait_expired(input int frames);
    int n;
    n = 0;
    while (expired !== 1'b1 && n < frames * hud_pkg::H_TOTAL * hud_pkg::V_TOTAL) begin
      next_cycle();
      n++;
    end
    if (expired !== 1'b1) begin
      timeouts++;
      $display("Timeout at %0t: timer did not expire", $time);
    end
  endtask

  task automatic start_timer(input int secs);
    load_seconds = 7'(secs);
    start        = 1'b1;
    next_cycle();
    start        = 1'b0;
  endtask

  // Pause level held for a random number of frames
  task automatic run_with_pauses;
    int segs;
    int level;
    int hold;
    random_bits(1, segs);
    for (int s = 0; s <= segs; s++) begin
      random_bits(1, level);
      random_bits(2, hold);
      pause = level[0];
      repeat (hold + 1) wait_frame_start();
    end
    pause = 1'b0;
  endtask

  initial begin
    int value;
    int gap;
    reset        = 1'b1;
    start        = 1'b0;
    pause        = 1'b0;
    load_seconds = '0;
    repeat (10) next_cycle();
    reset = 1'b0;
    repeat (2) wait_frame_start(); // Idle timer
    start_timer(127);              // Clamped to the maximum
    run_with_pauses();
    random_bits(2, value);
    start_timer(value + 1);
    wait_expired((value + 1) * hud_pkg::FRAMES_PER_SECOND + 2);
    wait_frame_start();
    start_timer(0);
    wait_expired(1);
    wait_frame_start();
    for (int run = 0; run < 6; run++) begin
      random_bits(7, value);
      random_bits(8, gap);
      repeat (gap) next_cycle();
      start_timer(value);
      run_with_pauses();
    end
    repeat (4) next_cycle();
    $display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts",
             mismatches, dut_i.props_i.failures, timeouts);
    if (mismatches == 0 && dut_i.props_i.failures == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: filelist.f
hdl/hud_pkg.sv
hdl/scan_if.sv
hdl/scan_timing.sv
hdl/game_timer.sv
hdl/timer_sprite.sv
hdl/hud_overlay.sv
hdl/hud_top.sv
bench/hud_props.sv
bench/hud_checker.sv
bench/hud_tb.sv
